//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Word and instruction field types
    ////////////////////////////////////////////////////////////////////////////
    typedef logic [15:0] word_t;
    typedef logic [1:0]  reg_idx_t;
    typedef logic [3:0]  opcode_t;
    typedef logic [5:0]  func_t;
    typedef logic [7:0]  imm_t;
    typedef logic [11:0] target_t;

    // Opcodes in bits 15..12
    localparam opcode_t op_bne   = 4'd0;
    localparam opcode_t op_beq   = 4'd1;
    localparam opcode_t op_bgz   = 4'd2;
    localparam opcode_t op_blz   = 4'd3;
    localparam opcode_t op_adi   = 4'd4;
    localparam opcode_t op_ori   = 4'd5;
    localparam opcode_t op_lhi   = 4'd6;
    localparam opcode_t op_lwd   = 4'd7;
    localparam opcode_t op_swd   = 4'd8;
    localparam opcode_t op_jmp   = 4'd9;
    localparam opcode_t op_jal   = 4'd10;
    localparam opcode_t op_rtype = 4'd15;

    // Function codes for the R-type opcode in bits 5..0
    localparam func_t fn_add = 6'd0;
    localparam func_t fn_sub = 6'd1;
    localparam func_t fn_and = 6'd2;
    localparam func_t fn_orr = 6'd3;
    localparam func_t fn_not = 6'd4;
    localparam func_t fn_tcp = 6'd5;
    localparam func_t fn_shl = 6'd6;
    localparam func_t fn_shr = 6'd7;
    localparam func_t fn_jpr = 6'd25;
    localparam func_t fn_jrl = 6'd26;
    localparam func_t fn_wwd = 6'd28;
    localparam func_t fn_hlt = 6'd29;

    // Return address register for JAL and JRL
    localparam reg_idx_t link_reg = 2'd2;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer state and datapath selects
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {st_if, st_id, st_ex_1, st_ex_2, st_mem, st_wb, st_halt} cpu_state_t;
    typedef enum logic [1:0] {alu_add, alu_sub, alu_func} alu_op_t;
    typedef enum logic {src_a_pc, src_a_reg} src_a_t;
    typedef enum logic [1:0] {src_b_reg, src_b_one, src_b_imm} src_b_t;
    typedef enum logic {pc_src_alu, pc_src_aluout} pc_src_t;
    typedef enum logic [1:0] {dest_rd, dest_rt, dest_link} dest_t;
    typedef enum logic {addr_pc, addr_aluout} addr_src_t;

endpackage

`default_nettype wire

//--- hw/mem_req_if.sv
`timescale 1ns/1ns
`default_nettype none

// One memory request at a time, shared by fetch and data access
interface mem_req_if
    import cpu_pkg::*;
();

    logic  rd;
    logic  wr;
    word_t addr;
    word_t wdata;
    word_t rdata;
    logic  done;

    modport ctrl (output rd, output wr, input done);

    modport data (output addr, output wdata, input rdata);

    // Sees the request, answers with read data and a done pulse
    modport master (input rd, input wr, input addr, input wdata, output rdata, output done);

endinterface

`default_nettype wire

//--- hw/wb_mem_master.sv
`timescale 1ns/1ns
`default_nettype none

module wb_mem_master
    import cpu_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset_n,
    mem_req_if.master  mreq,
    output logic       wb_cyc,
    output logic       wb_stb,
    output logic       wb_we,
    output word_t      wb_adr,
    output word_t      wb_wdata,
    input  wire word_t wb_rdata,
    input  wire logic  wb_ack
);

    typedef enum logic {bus_idle, bus_active} bus_state_t;

    bus_state_t state;
    logic       done_q;
    word_t      rdata_q;

    assign mreq.done  = done_q;
    assign mreq.rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state  <= bus_idle;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                bus_idle: begin
                    // A request still high in its done cycle is the old one
                    if ((mreq.rd || mreq.wr) && !done_q) begin
                        state  <= bus_active;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= mreq.wr;
                    end
                end
                bus_active: begin
                    if (wb_ack) begin
                        state  <= bus_idle;
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        wb_we  <= 1'b0;
                        done_q <= 1'b1;
                    end
                end
                default: state <= bus_idle;
            endcase
        end
    end

    // Address and data captured as the cycle opens, read data at the ack
    always_ff @(posedge clk) begin
        if (state == bus_idle) begin
            wb_adr   <= mreq.addr;
            wb_wdata <= mreq.wdata;
        end
        if (state == bus_active && wb_ack) begin
            rdata_q <= wb_rdata;
        end
    end

    a_stb_in_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        wb_stb |-> wb_cyc);

    a_stb_until_ack: assert property (@(posedge clk) disable iff (!reset_n)
        wb_stb && !wb_ack |=> wb_stb);

endmodule

`default_nettype wire

//--- hw/control_unit.sv
`timescale 1ns/1ns
`default_nettype none

module control_unit
    import cpu_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset_n,
    input  wire opcode_t opcode,
    input  wire func_t   func,
    input  wire logic    bcond,
    mem_req_if.ctrl      mreq,
    output logic         ir_write,
    output logic         mdr_write,
    output logic         pc_write,
    output logic         reg_write,
    output logic         out_write,
    output logic         halted,
    output addr_src_t    addr_src,
    output src_a_t       src_a,
    output src_b_t       src_b,
    output alu_op_t      alu_op,
    output pc_src_t      pc_src,
    output dest_t        dest,
    output logic         link_write,
    output logic         mem_to_reg
);

    cpu_state_t state;
    cpu_state_t next_state;

    logic is_alu, is_imm, is_load, is_store, is_branch;
    logic is_jump, is_link, is_wwd, is_halt;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction classes
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        is_alu    = (opcode == op_rtype) && (func <= fn_shr);
        is_imm    = (opcode == op_adi) || (opcode == op_ori) || (opcode == op_lhi);
        is_load   = (opcode == op_lwd);
        is_store  = (opcode == op_swd);
        is_branch = (opcode <= op_blz);
        is_jump   = (opcode == op_jmp) || (opcode == op_jal) ||
                    ((opcode == op_rtype) && ((func == fn_jpr) || (func == fn_jrl)));
        is_link   = (opcode == op_jal) || ((opcode == op_rtype) && (func == fn_jrl));
        is_wwd    = (opcode == op_rtype) && (func == fn_wwd);
        is_halt   = (opcode == op_rtype) && (func == fn_hlt);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Per-state control and next state
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        ir_write   = 1'b0;
        mdr_write  = 1'b0;
        pc_write   = 1'b0;
        reg_write  = 1'b0;
        out_write  = 1'b0;
        link_write = 1'b0;
        mem_to_reg = 1'b0;
        mreq.rd    = 1'b0;
        mreq.wr    = 1'b0;
        // Idle ALU setting is PC + 1
        addr_src   = addr_pc;
        src_a      = src_a_pc;
        src_b      = src_b_one;
        alu_op     = alu_add;
        pc_src     = pc_src_alu;
        dest       = dest_rd;
        next_state = state;
        case (state)
            st_if: begin
                mreq.rd = 1'b1;
                if (mreq.done) begin
                    ir_write   = 1'b1;
                    next_state = st_id;
                end
            end
            st_id: begin
                // ALUOut <- PC + 1, A and B load from the register file
                next_state = is_halt ? st_halt : st_ex_1;
            end
            st_ex_1: begin
                src_a  = src_a_reg;
                src_b  = is_alu ? src_b_reg : src_b_imm;
                alu_op = alu_func;
                if (is_branch) begin
                    // Subtract for the condition, PC steps past the branch
                    src_b      = src_b_reg;
                    alu_op     = alu_sub;
                    pc_write   = 1'b1;
                    pc_src     = pc_src_aluout;
                    next_state = bcond ? st_ex_2 : st_if;
                end else if (is_jump) begin
                    // Target into ALUOut, PC + 1 kept for the link
                    src_a      = (opcode == op_rtype) ? src_a_reg : src_a_pc;
                    pc_write   = 1'b1;
                    pc_src     = pc_src_aluout;
                    next_state = st_ex_2;
                end else if (is_alu || is_imm) begin
                    next_state = st_wb;
                end else if (is_load || is_store) begin
                    alu_op     = alu_add;
                    next_state = st_mem;
                end else begin
                    out_write  = is_wwd;
                    pc_write   = 1'b1;
                    pc_src     = pc_src_aluout;
                    next_state = st_if;
                end
            end
            st_ex_2: begin
                pc_write   = 1'b1;
                next_state = st_if;
                if (is_branch) begin
                    // PC already holds PC + 1
                    src_b = src_b_imm;
                end else begin
                    pc_src = pc_src_aluout;
                    if (is_link) begin
                        reg_write  = 1'b1;
                        dest       = dest_link;
                        link_write = 1'b1;
                    end
                end
            end
            st_mem: begin
                addr_src = addr_aluout;
                src_a    = src_a_reg;
                src_b    = src_b_imm;
                mreq.rd  = is_load;
                mreq.wr  = is_store;
                if (mreq.done) begin
                    if (is_load) begin
                        mdr_write  = 1'b1;
                        next_state = st_wb;
                    end else begin
                        src_a      = src_a_pc;
                        src_b      = src_b_one;
                        pc_write   = 1'b1;
                        next_state = st_if;
                    end
                end
            end
            st_wb: begin
                reg_write  = 1'b1;
                dest       = is_alu ? dest_rd : dest_rt;
                mem_to_reg = is_load;
                pc_write   = 1'b1;
                next_state = st_if;
            end
            default: next_state = st_halt;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= st_if;
        end else begin
            state <= next_state;
        end
    end

    assign halted = (state == st_halt);

    a_one_request: assert property (@(posedge clk) disable iff (!reset_n)
        !(mreq.rd && mreq.wr));

    // A request stays up unchanged until the bus master answers
    a_hold_request: assert property (@(posedge clk) disable iff (!reset_n)
        (mreq.rd || mreq.wr) && !mreq.done |=> $stable({mreq.rd, mreq.wr}));

endmodule

`default_nettype wire

//--- hw/datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath
    import cpu_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset_n,
    input  wire logic      ir_write,
    input  wire logic      mdr_write,
    input  wire logic      pc_write,
    input  wire logic      reg_write,
    input  wire logic      out_write,
    input  wire addr_src_t addr_src,
    input  wire src_a_t    src_a,
    input  wire src_b_t    src_b,
    input  wire alu_op_t   alu_op,
    input  wire pc_src_t   pc_src,
    input  wire dest_t     dest,
    input  wire logic      link_write,
    input  wire logic      mem_to_reg,
    mem_req_if.data        mreq,
    output opcode_t        opcode,
    output func_t          func,
    output logic           bcond,
    output word_t          output_port,
    output logic           output_valid
);

    word_t    pc, ir, mdr, a_q, b_q, alu_out;
    word_t    regs [4];
    word_t    ext_imm, alu_a, alu_b, alu_y, wb_value;
    imm_t     imm;
    target_t  target;
    reg_idx_t rs, rt, rd, wr_idx;

    assign opcode = ir[15:12];
    assign func   = ir[5:0];
    assign rs     = ir[11:10];
    assign rt     = ir[9:8];
    assign rd     = ir[7:6];
    assign imm    = ir[7:0];
    assign target = ir[11:0];

    assign mreq.addr  = (addr_src == addr_pc) ? pc : alu_out;
    assign mreq.wdata = b_q;

    // Immediate extension
    always_comb begin
        case (opcode)
            op_ori:  ext_imm = {8'h00, imm};
            op_lhi:  ext_imm = {imm, 8'h00};
            default: ext_imm = {{8{imm[7]}}, imm};
        endcase
    end

    assign alu_a = (src_a == src_a_pc) ? pc : a_q;

    always_comb begin
        case (src_b)
            src_b_reg: alu_b = b_q;
            src_b_one: alu_b = 16'd1;
            default:   alu_b = ext_imm;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        alu_y = alu_a + alu_b;
        if (alu_op == alu_sub) begin
            alu_y = alu_a - alu_b;
        end else if (alu_op == alu_func) begin
            case (opcode)
                op_ori:         alu_y = alu_a | alu_b;
                op_lhi:         alu_y = alu_b;
                // Jump target keeps the upper PC bits
                op_jmp, op_jal: alu_y = {alu_a[15:12], target};
                op_rtype: begin
                    case (func)
                        fn_sub:         alu_y = alu_a - alu_b;
                        fn_and:         alu_y = alu_a & alu_b;
                        fn_orr:         alu_y = alu_a | alu_b;
                        fn_not:         alu_y = ~alu_a;
                        fn_tcp:         alu_y = ~alu_a + 16'd1;
                        fn_shl:         alu_y = {alu_a[14:0], 1'b0};
                        fn_shr:         alu_y = {alu_a[15], alu_a[15:1]};
                        fn_jpr, fn_jrl: alu_y = alu_a;
                        default:        alu_y = alu_a + alu_b;
                    endcase
                end
                default: alu_y = alu_a + alu_b;
            endcase
        end
    end

    // Branch condition while the ALU subtracts A - B
    always_comb begin
        case (opcode)
            op_bne:  bcond = (alu_y != 16'd0);
            op_beq:  bcond = (alu_y == 16'd0);
            op_bgz:  bcond = !a_q[15] && (a_q != 16'd0);
            op_blz:  bcond = a_q[15];
            default: bcond = 1'b0;
        endcase
    end

    always_comb begin
        case (dest)
            dest_rd: wr_idx = rd;
            dest_rt: wr_idx = rt;
            default: wr_idx = link_reg;
        endcase
    end

    assign wb_value = link_write ? pc : (mem_to_reg ? mdr : alu_out);

    ////////////////////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc           <= 16'd0;
            output_valid <= 1'b0;
        end else begin
            if (pc_write) begin
                pc <= (pc_src == pc_src_alu) ? alu_y : alu_out;
            end
            output_valid <= out_write;
        end
    end

    always_ff @(posedge clk) begin
        if (ir_write) begin
            ir <= mreq.rdata;
        end
        if (mdr_write) begin
            mdr <= mreq.rdata;
        end
        if (reg_write) begin
            regs[wr_idx] <= wb_value;
        end
        if (out_write) begin
            output_port <= a_q;
        end
        a_q     <= regs[rs];
        b_q     <= regs[rt];
        alu_out <= alu_y;
    end

endmodule

`default_nettype wire

//--- hw/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top
    import cpu_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset_n,
    output logic       wb_cyc,
    output logic       wb_stb,
    output logic       wb_we,
    output word_t      wb_adr,
    output word_t      wb_wdata,
    input  wire word_t wb_rdata,
    input  wire logic  wb_ack,
    output word_t      output_port,
    output logic       output_valid,
    output logic       halted
);

    opcode_t   opcode;
    func_t     func;
    logic      bcond;
    logic      ir_write, mdr_write, pc_write, reg_write, out_write;
    logic      link_write, mem_to_reg;
    addr_src_t addr_src;
    src_a_t    src_a;
    src_b_t    src_b;
    alu_op_t   alu_op;
    pc_src_t   pc_src;
    dest_t     dest;

    mem_req_if mreq ();

    wb_mem_master u_bus (.clk, .reset_n, .mreq(mreq.master), .wb_cyc, .wb_stb, .wb_we,
                         .wb_adr, .wb_wdata, .wb_rdata, .wb_ack);

    control_unit u_ctrl (.clk, .reset_n, .opcode, .func, .bcond, .mreq(mreq.ctrl),
                         .ir_write, .mdr_write, .pc_write, .reg_write, .out_write,
                         .halted, .addr_src, .src_a, .src_b, .alu_op, .pc_src, .dest,
                         .link_write, .mem_to_reg);

    datapath u_dp (.clk, .reset_n, .ir_write, .mdr_write, .pc_write, .reg_write,
                   .out_write, .addr_src, .src_a, .src_b, .alu_op, .pc_src, .dest,
                   .link_write, .mem_to_reg, .mreq(mreq.data), .opcode, .func, .bcond,
                   .output_port, .output_valid);

endmodule

`default_nettype wire

//--- bench/cpu_checker.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_checker
    import cpu_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset_n,
    input  wire logic  output_valid,
    input  wire word_t output_port,
    input  wire logic  halted
);

    string test_name;
    word_t expected_q [$];
    word_t expected_word;
    logic  active = 1'b0;
    logic  halt_seen = 1'b0;
    int    out_count = 0;
    int    test_errors = 0;
    int    error_count = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction-set model that fills the list of expected WWD words
    ////////////////////////////////////////////////////////////////////////////
    function automatic void model_program(input word_t image [0:255]);
        word_t    m [0:255];
        word_t    r [0:3];
        word_t    pc, ins, sext, next_pc, ea, tgt;
        reg_idx_t rs, rt, rd;
        int       steps;
        logic     running;
        m = image;
        for (int i = 0; i < 4; i++) begin
            r[i] = 16'd0;
        end
        expected_q.delete();
        pc = 16'd0;
        running = 1'b1;
        steps = 0;
        while (running && steps < 5000) begin
            ins = m[pc[7:0]];
            rs = ins[11:10];
            rt = ins[9:8];
            rd = ins[7:6];
            sext = {{8{ins[7]}}, ins[7:0]};
            ea = r[rs] + sext;
            next_pc = pc + 16'd1;
            case (ins[15:12])
                op_bne: if (r[rs] != r[rt]) next_pc = pc + 16'd1 + sext;
                op_beq: if (r[rs] == r[rt]) next_pc = pc + 16'd1 + sext;
                op_bgz: if ($signed(r[rs]) > 0) next_pc = pc + 16'd1 + sext;
                op_blz: if ($signed(r[rs]) < 0) next_pc = pc + 16'd1 + sext;
                op_adi: r[rt] = r[rs] + sext;
                op_ori: r[rt] = r[rs] | {8'h00, ins[7:0]};
                op_lhi: r[rt] = {ins[7:0], 8'h00};
                op_lwd: r[rt] = m[ea[7:0]];
                op_swd: m[ea[7:0]] = r[rt];
                op_jmp: next_pc = {pc[15:12], ins[11:0]};
                op_jal: begin
                    r[link_reg] = pc + 16'd1;
                    next_pc = {pc[15:12], ins[11:0]};
                end
                op_rtype: begin
                    case (ins[5:0])
                        fn_add: r[rd] = r[rs] + r[rt];
                        fn_sub: r[rd] = r[rs] - r[rt];
                        fn_and: r[rd] = r[rs] & r[rt];
                        fn_orr: r[rd] = r[rs] | r[rt];
                        fn_not: r[rd] = ~r[rs];
                        fn_tcp: r[rd] = 16'd0 - r[rs];
                        fn_shl: r[rd] = r[rs] << 1;
                        fn_shr: r[rd] = $signed(r[rs]) >>> 1;
                        fn_jpr: next_pc = r[rs];
                        fn_jrl: begin
                            // Target read before the link is written
                            tgt = r[rs];
                            r[link_reg] = pc + 16'd1;
                            next_pc = tgt;
                        end
                        fn_wwd: expected_q.push_back(r[rs]);
                        fn_hlt: running = 1'b0;
                        default: ;
                    endcase
                end
                default: ;
            endcase
            pc = next_pc;
            steps++;
        end
    endfunction

    task automatic start_test(input string name, input word_t image [0:255]);
        test_name = name;
        model_program(image);
        out_count = 0;
        test_errors = 0;
        halt_seen = 1'b0;
        active = 1'b1;
    endtask

    task automatic note_timeout(input int cycles);
        $display("Test %s: halted did not rise within %0d cycles", test_name, cycles);
        test_errors++;
    endtask

    task automatic finish_test();
        if (expected_q.size() != 0) begin
            $display("Test %s: %0d expected output words never appeared",
                     test_name, expected_q.size());
            test_errors++;
        end
        error_count += test_errors;
        if (test_errors == 0) begin
            tests_passed++;
            $display("Test %s: pass, %0d output words checked", test_name, out_count);
        end else begin
            tests_failed++;
            $display("Test %s: fail, %0d errors", test_name, test_errors);
        end
        active = 1'b0;
    endtask

    task automatic report_counts();
        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
    endtask

    // Output words in order against the model and none after halt
    always @(posedge clk) begin
        if (active && reset_n) begin
            if (output_valid) begin
                out_count++;
                if (halt_seen) begin
                    $display("Test %s: output word %h appeared after halt",
                             test_name, output_port);
                    test_errors++;
                end else if (expected_q.size() == 0) begin
                    $display("Test %s: extra output word %h beyond the expected list",
                             test_name, output_port);
                    test_errors++;
                end else begin
                    expected_word = expected_q.pop_front();
                    if (output_port !== expected_word) begin
                        $display("MISMATCH test %s output %0d: expected %h, actual %h",
                                 test_name, out_count, expected_word, output_port);
                        test_errors++;
                    end
                end
            end
            if (halt_seen && !halted) begin
                $display("Test %s: halted fell before reset", test_name);
                test_errors++;
                halt_seen = 1'b0;
            end
            if (halted) begin
                halt_seen = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_cpu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu
    import cpu_pkg::*;
();

    localparam int halt_timeout = 4000;
    localparam int quiet_cycles = 8;

    logic        clk;
    logic        reset_n;
    logic        wb_cyc, wb_stb, wb_we, wb_ack;
    word_t       wb_adr, wb_wdata, wb_rdata;
    word_t       output_port;
    logic        output_valid, halted;

    word_t       mem [0:255];
    logic [1:0]  wait_left;
    logic [31:0] wait_rng;
    logic [31:0] stim_rng;
    int          prog_len;

    cpu_top uut (.clk, .reset_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata,
                 .wb_rdata, .wb_ack, .output_port, .output_valid, .halted);

    cpu_checker u_check (.clk, .reset_n, .output_valid, .output_port, .halted);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone memory with 0 to 3 wait states per bus cycle
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        wb_ack <= 1'b0;
        if (wb_cyc && wb_stb && !wb_ack) begin
            if (wait_left == 2'd0) begin
                wb_ack <= 1'b1;
                if (wb_we) begin
                    mem[wb_adr[7:0]] <= wb_wdata;
                end else begin
                    wb_rdata <= mem[wb_adr[7:0]];
                end
                // Wait count for the next cycle
                wait_rng = xorshift32(wait_rng);
                wait_left <= wait_rng[1:0];
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Program builder
    ////////////////////////////////////////////////////////////////////////////
    function automatic word_t random_word();
        stim_rng = xorshift32(stim_rng);
        return stim_rng[15:0];
    endfunction

    function automatic word_t encode_rtype(func_t fn, reg_idx_t rs, reg_idx_t rt,
                                           reg_idx_t rd);
        return {op_rtype, rs, rt, rd, fn};
    endfunction

    function automatic word_t encode_itype(opcode_t op, reg_idx_t rs, reg_idx_t rt, imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t encode_jump(opcode_t op, target_t target);
        return {op, target};
    endfunction

    task automatic clear_memory();
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0] ^ 8'h5a, ~i[7:0]};
        end
        prog_len = 0;
    endtask

    task automatic emit(input word_t w);
        mem[prog_len] = w;
        prog_len++;
    endtask

    task automatic emit_wwd(input reg_idx_t r);
        emit(encode_rtype(fn_wwd, r, 2'd0, 2'd0));
    endtask

    task automatic emit_halt();
        emit(encode_rtype(fn_hlt, 2'd0, 2'd0, 2'd0));
    endtask

    // Full 16-bit constant with LHI then ORI
    task automatic load_const(input reg_idx_t r, input word_t value);
        emit(encode_itype(op_lhi, 2'd0, r, value[15:8]));
        emit(encode_itype(op_ori, r, r, value[7:0]));
    endtask

    // Fall-through marker first and the taken marker at PC + 1 + 3
    task automatic emit_branch_case(input opcode_t op, input reg_idx_t rs, input reg_idx_t rt,
                                    input imm_t mark);
        int at;
        at = prog_len;
        emit(encode_itype(op, rs, rt, 8'd3));
        emit(encode_itype(op_lhi, 2'd0, 2'd3, mark));
        emit_wwd(2'd3);
        emit(encode_jump(op_jmp, target_t'(at + 6)));
        emit(encode_itype(op_lhi, 2'd0, 2'd3, mark | 8'h80));
        emit_wwd(2'd3);
    endtask

    task automatic build_alu_test();
        word_t x, y;
        clear_memory();
        for (int round = 0; round < 3; round++) begin
            x = random_word();
            y = random_word();
            if (round == 0) begin
                x[15] = 1'b1;
            end
            load_const(2'd0, x);
            load_const(2'd1, y);
            for (int f = 0; f <= 7; f++) begin
                emit(encode_rtype(func_t'(f), 2'd0, 2'd1, 2'd3));
                emit_wwd(2'd3);
            end
        end
        emit_halt();
    endtask

    task automatic build_imm_test();
        clear_memory();
        emit(encode_itype(op_lhi, 2'd0, 2'd0, 8'h00));
        emit(encode_itype(op_adi, 2'd0, 2'd1, 8'hf6));
        emit_wwd(2'd1);
        emit(encode_itype(op_adi, 2'd1, 2'd1, 8'h7f));
        emit_wwd(2'd1);
        emit(encode_itype(op_ori, 2'd0, 2'd2, 8'hf0));
        emit_wwd(2'd2);
        emit(encode_itype(op_lhi, 2'd0, 2'd3, 8'hc3));
        emit_wwd(2'd3);
        emit(encode_itype(op_ori, 2'd3, 2'd3, 8'h81));
        emit_wwd(2'd3);
        emit(encode_itype(op_adi, 2'd3, 2'd2, 8'h80));
        emit_wwd(2'd2);
        emit_halt();
    endtask

    task automatic build_mem_test();
        word_t value;
        imm_t  offs [4];
        clear_memory();
        // Data area from 0x80 lies clear of the program
        load_const(2'd0, 16'h0080);
        for (int k = 0; k < 4; k++) begin
            value = random_word();
            offs[k] = {2'b00, value[5:0]};
            load_const(2'd1, random_word());
            emit(encode_itype(op_swd, 2'd0, 2'd1, offs[k]));
        end
        for (int k = 0; k < 4; k++) begin
            emit(encode_itype(op_lwd, 2'd0, 2'd2, offs[k]));
            emit_wwd(2'd2);
        end
        emit_halt();
    endtask

    task automatic build_branch_test();
        clear_memory();
        load_const(2'd0, 16'd5);
        load_const(2'd1, 16'd5);
        load_const(2'd2, 16'hfffd);
        emit_branch_case(op_bne, 2'd0, 2'd1, 8'h01);
        emit_branch_case(op_bne, 2'd0, 2'd2, 8'h02);
        emit_branch_case(op_beq, 2'd0, 2'd1, 8'h03);
        emit_branch_case(op_beq, 2'd0, 2'd2, 8'h04);
        emit_branch_case(op_bgz, 2'd0, 2'd0, 8'h05);
        emit_branch_case(op_bgz, 2'd2, 2'd0, 8'h06);
        emit_branch_case(op_blz, 2'd2, 2'd0, 8'h07);
        emit_branch_case(op_blz, 2'd0, 2'd0, 8'h08);
        emit_halt();
    endtask

    task automatic build_jump_test();
        int skip_at, jal_at, ori_at, sub_at, sub2_at;
        clear_memory();
        emit(encode_itype(op_lhi, 2'd0, 2'd0, 8'h00));
        skip_at = prog_len;
        emit(16'h0000);
        // Skipped by the JMP
        emit(encode_itype(op_lhi, 2'd0, 2'd3, 8'hee));
        emit_wwd(2'd3);
        mem[skip_at] = encode_jump(op_jmp, target_t'(prog_len));
        jal_at = prog_len;
        emit(16'h0000);
        emit_wwd(2'd2);
        ori_at = prog_len;
        emit(16'h0000);
        emit(encode_rtype(fn_jrl, 2'd1, 2'd0, 2'd0));
        emit_wwd(2'd2);
        emit_halt();
        sub_at = prog_len;
        emit_wwd(2'd2);
        emit(encode_rtype(fn_jpr, 2'd2, 2'd0, 2'd0));
        sub2_at = prog_len;
        emit(encode_itype(op_lhi, 2'd0, 2'd3, 8'h5c));
        emit_wwd(2'd3);
        emit(encode_rtype(fn_jpr, 2'd2, 2'd0, 2'd0));
        mem[jal_at] = encode_jump(op_jal, target_t'(sub_at));
        mem[ori_at] = encode_itype(op_ori, 2'd0, 2'd1, imm_t'(sub2_at));
    endtask

    task automatic build_halt_test();
        clear_memory();
        emit(encode_itype(op_lhi, 2'd0, 2'd3, 8'h11));
        emit_wwd(2'd3);
        emit_halt();
        // Never reached
        emit_wwd(2'd3);
        emit(encode_itype(op_lhi, 2'd0, 2'd3, 8'h22));
        emit_wwd(2'd3);
        emit_halt();
    endtask

    task automatic run_program(input string name);
        int cycles;
        @(posedge clk);
        reset_n <= 1'b0;
        repeat (3) @(posedge clk);
        u_check.start_test(name, mem);
        reset_n <= 1'b1;
        cycles = 0;
        while (!halted && cycles < halt_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            u_check.note_timeout(halt_timeout);
        end
        // Watch window for stray outputs after halt
        repeat (quiet_cycles) @(negedge clk);
        u_check.finish_test();
    endtask

    initial begin
        clk       = 1'b0;
        reset_n   = 1'b0;
        wb_rdata  = 16'd0;
        wb_ack    = 1'b0;
        wait_left = 2'd0;
        wait_rng  = 32'hf3ab_7b4b;
        stim_rng  = 32'hf3ab_7b4b;
        build_alu_test();
        run_program("alu_rtype");
        build_imm_test();
        run_program("immediates");
        build_mem_test();
        run_program("memory");
        build_branch_test();
        run_program("branches");
        build_jump_test();
        run_program("jumps");
        build_halt_test();
        run_program("halt");
        u_check.report_counts();
        if (u_check.error_count == 0 && u_check.tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hw/cpu_pkg.sv
hw/mem_req_if.sv
hw/wb_mem_master.sv
hw/control_unit.sv
hw/datapath.sv
hw/cpu_top.sv
bench/cpu_checker.sv
bench/tb_cpu.sv
